// ==== Makefile ====
TOP = bus_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== all.f ====
hw/bus_pkg.sv
hw/bus_clint.sv
hw/bus_uart_tx.sv
hw/bus_arbiter_ctrl.sv
hw/bus_top.sv
dv/axi_mem_model.sv
dv/bus_chk.sv
dv/bus_tb.sv

// ==== dv/axi_mem_model.sv ====
module axi_mem_model (
  input  logic           clk,
  input  logic           rst,
  input  bus_pkg::addr_t araddr_i,
  input  logic           arvalid_i,
  output logic           arready_o,
  output bus_pkg::data_t rdata_o,
  output logic           rvalid_o,
  input  logic           rready_i,
  input  bus_pkg::addr_t awaddr_i,
  input  logic           awvalid_i,
  output logic           awready_o,
  input  bus_pkg::data_t wdata_i,
  input  bus_pkg::strb_t wstrb_i,
  input  logic           wvalid_i,
  output logic           wready_o,
  output logic           bvalid_o,
  input  logic           bready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // 1K words, aliased over address bits 11:2
  // contents are loaded by the testbench before reset ends
  bus_pkg::data_t mem [0:1023];

  logic [1:0]     ar_wait;
  logic [1:0]     r_wait;
  logic [1:0]     aw_wait;
  logic [1:0]     w_wait;
  logic [1:0]     b_wait;
  logic           rd_pend;
  logic           aw_done;
  logic           w_done;
  bus_pkg::addr_t rd_addr;
  bus_pkg::addr_t wr_addr;
  bus_pkg::data_t wr_data;
  bus_pkg::strb_t wr_strb;

  // read side
  always @(posedge clk)
  begin
    if (rst)
    begin
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      rdata_o   <= '0;
      rd_pend   <= 1'b0;
      ar_wait   <= 2'd0;
      r_wait    <= 2'd0;
    end
    else
    begin
      arready_o <= 1'b0;
      if (arvalid_i && arready_o)
      begin
        rd_addr <= araddr_i;
        rd_pend <= 1'b1;
        ar_wait <= 2'($urandom());
        r_wait  <= 2'($urandom());
      end
      else if (arvalid_i && !rd_pend)
      begin
        if (ar_wait == 2'd0)
          arready_o <= 1'b1;
        else
          ar_wait <= ar_wait - 2'd1;
      end
      if (rvalid_o && rready_i)
      begin
        rvalid_o <= 1'b0;
        rd_pend  <= 1'b0;
      end
      else if (rd_pend && !rvalid_o)
      begin
        if (r_wait == 2'd0)
        begin
          rvalid_o <= 1'b1;
          rdata_o  <= mem[rd_addr[11:2]];
        end
        else
          r_wait <= r_wait - 2'd1;
      end
    end
  end

  // write side, address and data accepted independently
  always @(posedge clk)
  begin
    if (rst)
    begin
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      aw_done   <= 1'b0;
      w_done    <= 1'b0;
      aw_wait   <= 2'd0;
      w_wait    <= 2'd0;
      b_wait    <= 2'd0;
    end
    else
    begin
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      if (awvalid_i && awready_o)
      begin
        wr_addr <= awaddr_i;
        aw_done <= 1'b1;
        aw_wait <= 2'($urandom());
      end
      else if (awvalid_i && !aw_done)
      begin
        if (aw_wait == 2'd0)
          awready_o <= 1'b1;
        else
          aw_wait <= aw_wait - 2'd1;
      end
      if (wvalid_i && wready_o)
      begin
        wr_data <= wdata_i;
        wr_strb <= wstrb_i;
        w_done  <= 1'b1;
        w_wait  <= 2'($urandom());
      end
      else if (wvalid_i && !w_done)
      begin
        if (w_wait == 2'd0)
          wready_o <= 1'b1;
        else
          w_wait <= w_wait - 2'd1;
      end
      if (bvalid_o && bready_i)
      begin
        bvalid_o <= 1'b0;
        aw_done  <= 1'b0;
        w_done   <= 1'b0;
        b_wait   <= 2'($urandom());
      end
      else if (aw_done && w_done && !bvalid_o)
      begin
        if (b_wait == 2'd0)
        begin
          bvalid_o <= 1'b1;
          for (int i = 0; i < 4; i++)
            if (wr_strb[i])
              mem[wr_addr[11:2]][8*i +: 8] <= wr_data[8*i +: 8];
        end
        else
          b_wait <= b_wait - 2'd1;
      end
    end
  end

endmodule

// ==== dv/bus_chk.sv ====
module bus_chk (
  input logic           clk,
  input logic           rst,
  input logic           arvalid_i,
  input logic           arready_i,
  input bus_pkg::addr_t araddr_i,
  input logic           awvalid_i,
  input logic           awready_i,
  input bus_pkg::addr_t awaddr_i,
  input logic           wvalid_i,
  input logic           wready_i,
  input bus_pkg::data_t wdata_i,
  input logic           rvalid_i,
  input logic           rready_i,
  input logic           ifu_req_i,
  input logic           lsu_rd_req_i,
  input logic           ifu_rvalid_i,
  input logic           lsu_rvalid_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // valid held with stable payload until the transfer
  ar_hold: assert property (@(posedge clk) disable iff (rst)
    arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
    else $error("arvalid dropped or araddr changed before arready");

  aw_hold: assert property (@(posedge clk) disable iff (rst)
    awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
    else $error("awvalid dropped or awaddr changed before awready");

  w_hold: assert property (@(posedge clk) disable iff (rst)
    wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i))
    else $error("wvalid dropped or wdata changed before wready");

  // read pulses go only to a port that is asking and never together
  ifu_pulse_owner: assert property (@(posedge clk) disable iff (rst)
    ifu_rvalid_i |-> ifu_req_i && !lsu_rvalid_i)
    else $error("ifu read pulse without ifu request or together with lsu pulse");

  lsu_pulse_owner: assert property (@(posedge clk) disable iff (rst)
    lsu_rvalid_i |-> lsu_rd_req_i)
    else $error("lsu read pulse without lsu read request");

  // rready spans from the AR transfer to the R transfer
  rready_rise: assert property (@(posedge clk) disable iff (rst)
    $rose(rready_i) |-> $past(arvalid_i && arready_i))
    else $error("rready raised without an AR transfer");

  rready_hold: assert property (@(posedge clk) disable iff (rst)
    rready_i && !rvalid_i |=> rready_i)
    else $error("rready dropped before the R transfer");

  rready_drop: assert property (@(posedge clk) disable iff (rst)
    rready_i && rvalid_i |=> !rready_i)
    else $error("rready still high after the R transfer");

endmodule

bind bus_arbiter_ctrl bus_chk bus_chk_i (
  .clk          (clk),
  .rst          (rst),
  .arvalid_i    (m_arvalid_o),
  .arready_i    (m_arready_i),
  .araddr_i     (m_araddr_o),
  .awvalid_i    (m_awvalid_o),
  .awready_i    (m_awready_i),
  .awaddr_i     (m_awaddr_o),
  .wvalid_i     (m_wvalid_o),
  .wready_i     (m_wready_i),
  .wdata_i      (m_wdata_o),
  .rvalid_i     (m_rvalid_i),
  .rready_i     (m_rready_o),
  .ifu_req_i    (ifu_req_i),
  .lsu_rd_req_i (lsu_rd_req_i),
  .ifu_rvalid_i (ifu_rvalid_o),
  .lsu_rvalid_i (lsu_rvalid_o)
);

// ==== dv/bus_tb.sv ====
module bus_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int             BAUD_DIV = 4;
  localparam int             NUM_OPS  = 50;
  localparam time            CLK_NS   = 100;
  localparam time            LIMIT_NS = time'(NUM_OPS * (10 * BAUD_DIV + 20)) * CLK_NS;
  localparam bus_pkg::addr_t MEM_BASE = 32'h8000_0000;

  logic           clk = 1'b0;
  logic           rst;
  bus_pkg::addr_t ifu_addr;
  logic           ifu_req;
  bus_pkg::data_t ifu_rdata;
  logic           ifu_rvalid;
  bus_pkg::addr_t lsu_addr;
  logic           lsu_rd_req;
  logic           lsu_wr_req;
  bus_pkg::data_t lsu_wdata;
  bus_pkg::strb_t lsu_wstrb;
  bus_pkg::data_t lsu_rdata;
  logic           lsu_rvalid;
  logic           lsu_wready;
  bus_pkg::addr_t m_araddr;
  logic           m_arvalid;
  logic           m_arready;
  bus_pkg::data_t m_rdata;
  logic           m_rvalid;
  logic           m_rready;
  bus_pkg::addr_t m_awaddr;
  logic           m_awvalid;
  logic           m_awready;
  bus_pkg::data_t m_wdata;
  bus_pkg::strb_t m_wstrb;
  logic           m_wvalid;
  logic           m_wready;
  logic           m_bvalid;
  logic           m_bready;
  logic           uart_tx;
  logic           timer_irq;

  // expected external memory contents
  bus_pkg::data_t shadow [0:1023];
  int             errors;
  int             checks;

  bus_top #(
    .BAUD_DIV (BAUD_DIV)
  ) bus_top_i (
    .clk (clk), .rst (rst),
    .ifu_addr_i (ifu_addr), .ifu_req_i (ifu_req),
    .ifu_rdata_o (ifu_rdata), .ifu_rvalid_o (ifu_rvalid),
    .lsu_addr_i (lsu_addr), .lsu_rd_req_i (lsu_rd_req), .lsu_wr_req_i (lsu_wr_req),
    .lsu_wdata_i (lsu_wdata), .lsu_wstrb_i (lsu_wstrb),
    .lsu_rdata_o (lsu_rdata), .lsu_rvalid_o (lsu_rvalid), .lsu_wready_o (lsu_wready),
    .m_araddr_o (m_araddr), .m_arvalid_o (m_arvalid), .m_arready_i (m_arready),
    .m_rdata_i (m_rdata), .m_rvalid_i (m_rvalid), .m_rready_o (m_rready),
    .m_awaddr_o (m_awaddr), .m_awvalid_o (m_awvalid), .m_awready_i (m_awready),
    .m_wdata_o (m_wdata), .m_wstrb_o (m_wstrb), .m_wvalid_o (m_wvalid),
    .m_wready_i (m_wready), .m_bvalid_i (m_bvalid), .m_bready_o (m_bready),
    .uart_tx_o (uart_tx), .timer_irq_o (timer_irq)
  );

  axi_mem_model axi_mem_model_i (
    .clk (clk), .rst (rst),
    .araddr_i (m_araddr), .arvalid_i (m_arvalid), .arready_o (m_arready),
    .rdata_o (m_rdata), .rvalid_o (m_rvalid), .rready_i (m_rready),
    .awaddr_i (m_awaddr), .awvalid_i (m_awvalid), .awready_o (m_awready),
    .wdata_i (m_wdata), .wstrb_i (m_wstrb), .wvalid_i (m_wvalid), .wready_o (m_wready),
    .bvalid_o (m_bvalid), .bready_i (m_bready)
  );

  always #(CLK_NS / 2) clk = ~clk;

  // fill pattern over the full byte address
  function automatic bus_pkg::data_t mem_init(bus_pkg::addr_t addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
  endfunction

  // old word with the strobed bytes taken from the store
  function automatic bus_pkg::data_t merge_strobe(bus_pkg::data_t old_w,
                                                  bus_pkg::data_t new_w,
                                                  bus_pkg::strb_t strb);
    bus_pkg::data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++)
      if (strb[b])
        res[8*b +: 8] = new_w[8*b +: 8];
    return res;
  endfunction

  task automatic check_data(string name, bus_pkg::data_t got, bus_pkg::data_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_byte(string name, bus_pkg::byte_t got, bus_pkg::byte_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %0t %s got %b exp %b", $time, name, got, exp);
    end
  endtask

  task automatic report_problem(string what);
    errors++;
    $display("%0t %s", $time, what);
  endtask

  task automatic print_test_result(string name, int err_before);
    $display("test %s: %0d errors", name, errors - err_before);
  endtask

  task automatic ifu_read(bus_pkg::addr_t addr, output bus_pkg::data_t data, output time t);
    @(posedge clk);
    #5;
    ifu_addr = addr;
    ifu_req  = 1'b1;
    @(negedge clk);
    while (ifu_rvalid !== 1'b1)
      @(negedge clk);
    data = ifu_rdata;
    t    = $time;
    @(posedge clk);
    #5;
    ifu_req = 1'b0;
  endtask

  task automatic lsu_read(bus_pkg::addr_t addr, output bus_pkg::data_t data, output time t);
    @(posedge clk);
    #5;
    lsu_addr   = addr;
    lsu_rd_req = 1'b1;
    @(negedge clk);
    while (lsu_rvalid !== 1'b1)
      @(negedge clk);
    data = lsu_rdata;
    t    = $time;
    @(posedge clk);
    #5;
    lsu_rd_req = 1'b0;
  endtask

  task automatic lsu_write(bus_pkg::addr_t addr, bus_pkg::data_t data, bus_pkg::strb_t strb,
                           output time t);
    @(posedge clk);
    #5;
    lsu_addr   = addr;
    lsu_wdata  = data;
    lsu_wstrb  = strb;
    lsu_wr_req = 1'b1;
    @(negedge clk);
    while (lsu_wready !== 1'b1)
      @(negedge clk);
    t = $time;
    @(posedge clk);
    #5;
    lsu_wr_req = 1'b0;
  endtask

  // 8N1 decode sampled near the middle of each bit
  task automatic uart_receive(output bus_pkg::byte_t b, output time start);
    @(negedge clk);
    while (uart_tx !== 1'b0)
      @(negedge clk);
    start = $time - CLK_NS / 2;
    repeat (BAUD_DIV / 2) @(negedge clk);
    if (uart_tx !== 1'b0)
      report_problem("serial start bit did not stay low to mid-bit");
    for (int i = 0; i < 8; i++)
    begin
      repeat (BAUD_DIV) @(negedge clk);
      b[i] = uart_tx;
    end
    repeat (BAUD_DIV) @(negedge clk);
    if (uart_tx !== 1'b1)
      report_problem("serial stop bit was not high");
  endtask

  initial
  begin
    #(LIMIT_NS);
    $display("timeout after %0d ns, a response never arrived", LIMIT_NS);
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    bus_pkg::data_t rd;
    bus_pkg::data_t rd2;
    bus_pkg::data_t wd;
    bus_pkg::data_t wd2;
    bus_pkg::strb_t st;
    bus_pkg::addr_t a;
    bus_pkg::addr_t a2;
    bus_pkg::byte_t rx0;
    bus_pkg::byte_t rx1;
    time            t_ifu;
    time            t_lsu;
    time            t_wr1;
    time            ts0;
    time            ts1;
    int             idx;
    int             idx2;
    int             err0;
    int             n;

    void'($urandom(32'h9e5d_012c));
    errors     = 0;
    checks     = 0;
    rst        = 1'b1;
    ifu_addr   = '0;
    ifu_req    = 1'b0;
    lsu_addr   = '0;
    lsu_rd_req = 1'b0;
    lsu_wr_req = 1'b0;
    lsu_wdata  = '0;
    lsu_wstrb  = '0;
    for (int i = 0; i < 1024; i++)
    begin
      shadow[i] = mem_init(MEM_BASE + 32'(i * 4));
      axi_mem_model_i.mem[i] = shadow[i];
    end
    repeat (10) @(posedge clk);
    #5;
    rst = 1'b0;

    err0 = errors;
    check_bit("uart_tx_o", uart_tx, 1'b1);
    check_bit("timer_irq_o", timer_irq, 1'b0);
    check_bit("m_arvalid_o", m_arvalid, 1'b0);
    check_bit("m_awvalid_o", m_awvalid, 1'b0);
    check_bit("m_wvalid_o", m_wvalid, 1'b0);
    check_bit("m_rready_o", m_rready, 1'b0);
    check_bit("m_bready_o", m_bready, 1'b0);
    check_bit("ifu_rvalid_o", ifu_rvalid, 1'b0);
    check_bit("lsu_rvalid_o", lsu_rvalid, 1'b0);
    check_bit("lsu_wready_o", lsu_wready, 1'b0);
    print_test_result("reset state", err0);

    err0 = errors;
    for (n = 0; n < 20; n++)
    begin
      idx = int'($urandom() % 1024);
      a   = MEM_BASE + 32'(idx * 4);
      ifu_read(a, rd, t_ifu);
      check_data("ifu_rdata_o", rd, shadow[idx]);
    end
    print_test_result("ifu reads", err0);

    err0 = errors;
    for (n = 0; n < 8; n++)
    begin
      idx = int'($urandom() % 1024);
      a   = MEM_BASE + 32'(idx * 4);
      wd  = $urandom();
      st  = 4'($urandom());
      lsu_write(a, wd, st, t_lsu);
      shadow[idx] = merge_strobe(shadow[idx], wd, st);
      lsu_read(a, rd, t_lsu);
      check_data("lsu_rdata_o", rd, shadow[idx]);
    end
    print_test_result("strobed stores", err0);

    err0 = errors;
    idx  = int'($urandom() % 1024);
    idx2 = int'($urandom() % 1024);
    a    = MEM_BASE + 32'(idx * 4);
    a2   = MEM_BASE + 32'(idx2 * 4);
    fork
      ifu_read(a, rd, t_ifu);
      lsu_read(a2, rd2, t_lsu);
    join
    check_data("ifu_rdata_o", rd, shadow[idx]);
    check_data("lsu_rdata_o", rd2, shadow[idx2]);
    if (t_lsu >= t_ifu)
      report_problem("lsu response did not come before the ifu response");
    print_test_result("arbitration", err0);

    err0 = errors;
    wd   = $urandom();
    wd2  = $urandom();
    fork
      begin
        uart_receive(rx0, ts0);
        uart_receive(rx1, ts1);
      end
      begin
        lsu_write(bus_pkg::UART_TX_ADDR, wd, 4'hf, t_lsu);
        lsu_write(bus_pkg::UART_TX_ADDR, wd2, 4'hf, t_wr1);
      end
    join
    check_byte("uart_tx_o frame 0", rx0, wd[7:0]);
    check_byte("uart_tx_o frame 1", rx1, wd2[7:0]);
    if (t_wr1 <= ts0 + time'(10 * BAUD_DIV) * CLK_NS)
      report_problem("second serial store finished before the first stop bit ended");
    print_test_result("serial tx", err0);

    err0 = errors;
    lsu_read(bus_pkg::CLINT_BASE + 32'd8, rd, t_lsu);
    lsu_read(bus_pkg::CLINT_BASE + 32'd8, rd2, t_lsu);
    if (rd2 <= rd)
      report_problem("mtime low did not increase between two reads");
    wd  = $urandom();
    wd2 = $urandom() | 32'h8000_0000;
    lsu_write(bus_pkg::CLINT_BASE, wd, 4'hf, t_lsu);
    lsu_write(bus_pkg::CLINT_BASE + 32'd4, wd2, 4'hf, t_lsu);
    lsu_read(bus_pkg::CLINT_BASE, rd, t_lsu);
    check_data("mtimecmp low", rd, wd);
    lsu_read(bus_pkg::CLINT_BASE + 32'd4, rd, t_lsu);
    check_data("mtimecmp high", rd, wd2);
    // compare point 50 ticks ahead with the high word written last
    lsu_read(bus_pkg::CLINT_BASE + 32'd8, rd, t_lsu);
    lsu_write(bus_pkg::CLINT_BASE, rd + 32'd50, 4'hf, t_lsu);
    lsu_write(bus_pkg::CLINT_BASE + 32'd4, 32'h0, 4'hf, t_lsu);
    check_bit("timer_irq_o", timer_irq, 1'b0);
    n = 0;
    while ((timer_irq !== 1'b1) && (n < 60))
    begin
      @(negedge clk);
      n++;
    end
    if (timer_irq !== 1'b1)
      report_problem("timer interrupt not raised within 60 cycles");
    print_test_result("timer", err0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== hw/bus_arbiter_ctrl.sv ====
module bus_arbiter_ctrl (
  input  logic               clk,
  input  logic               rst,

  // instruction fetch port
  input  bus_pkg::addr_t     ifu_addr_i,
  input  logic               ifu_req_i,
  output bus_pkg::data_t     ifu_rdata_o,
  output logic               ifu_rvalid_o,

  // load/store port
  input  bus_pkg::addr_t     lsu_addr_i,
  input  logic               lsu_rd_req_i,
  input  logic               lsu_wr_req_i,
  input  bus_pkg::data_t     lsu_wdata_i,
  input  bus_pkg::strb_t     lsu_wstrb_i,
  output bus_pkg::data_t     lsu_rdata_o,
  output logic               lsu_rvalid_o,
  output logic               lsu_wready_o,

  // external single-beat master
  output bus_pkg::addr_t     m_araddr_o,
  output logic               m_arvalid_o,
  input  logic               m_arready_i,
  input  bus_pkg::data_t     m_rdata_i,
  input  logic               m_rvalid_i,
  output logic               m_rready_o,
  output bus_pkg::addr_t     m_awaddr_o,
  output logic               m_awvalid_o,
  input  logic               m_awready_i,
  output bus_pkg::data_t     m_wdata_o,
  output bus_pkg::strb_t     m_wstrb_o,
  output logic               m_wvalid_o,
  input  logic               m_wready_i,
  input  logic               m_bvalid_i,
  output logic               m_bready_o,

  // timer block
  output logic               clint_wr_en_o,
  output bus_pkg::clint_reg_t clint_reg_o,
  output bus_pkg::data_t     clint_wdata_o,
  input  bus_pkg::data_t     clint_rdata_i,

  // serial transmitter
  output logic               uart_wr_en_o,
  output bus_pkg::byte_t     uart_data_o,
  input  logic               uart_busy_i
);

  bus_pkg::arb_state_e state_q, state_d;

  logic           grant_lsu;
  logic           grant_any;
  logic           accept;
  logic           hit_clint;
  logic           hit_uart;
  bus_pkg::addr_t sel_addr;
  bus_pkg::data_t local_rdata;

  // owner of the transaction in flight
  logic           is_lsu_q;
  logic           is_wr_q;
  // address and data channels still to hand over
  logic           aw_pend_q;
  logic           w_pend_q;

  bus_pkg::addr_t addr_q;
  bus_pkg::data_t wdata_q;
  bus_pkg::strb_t wstrb_q;
  bus_pkg::data_t rdata_q;

  // load/store before fetch
  assign grant_lsu = lsu_wr_req_i | lsu_rd_req_i;
  assign grant_any = grant_lsu | ifu_req_i;
  assign sel_addr  = grant_lsu ? lsu_addr_i : ifu_addr_i;
  assign accept    = (state_q == bus_pkg::IDLE) && grant_any;

  assign hit_clint = (sel_addr >= bus_pkg::CLINT_BASE) &&
                     (sel_addr < bus_pkg::CLINT_BASE + bus_pkg::CLINT_SIZE);
  assign hit_uart  = (sel_addr == bus_pkg::UART_TX_ADDR);

  // reads of the transmit register return zero
  assign local_rdata = hit_clint ? clint_rdata_i : '0;

  // timer access happens on the accept edge
  assign clint_wr_en_o = accept && lsu_wr_req_i && hit_clint;
  assign clint_reg_o   = sel_addr[3:2];
  assign clint_wdata_o = lsu_wdata_i;

  assign uart_wr_en_o = (state_q == bus_pkg::UART_WAIT) && !uart_busy_i;
  assign uart_data_o  = wdata_q[7:0];

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      bus_pkg::IDLE:
      begin
        if (grant_any)
        begin
          if (hit_clint || (hit_uart && !lsu_wr_req_i))
            state_d = bus_pkg::LOCAL_RESP;
          else if (hit_uart)
            state_d = bus_pkg::UART_WAIT;
          else if (lsu_wr_req_i)
            state_d = bus_pkg::AW_W;
          else
            state_d = bus_pkg::AR;
        end
      end
      bus_pkg::AR:
        if (m_arready_i)
          state_d = bus_pkg::R;
      bus_pkg::R:
        if (m_rvalid_i)
          state_d = bus_pkg::LOCAL_RESP;
      bus_pkg::AW_W:
        if ((!aw_pend_q || m_awready_i) && (!w_pend_q || m_wready_i))
          state_d = bus_pkg::B;
      bus_pkg::B:
        if (m_bvalid_i)
          state_d = bus_pkg::LOCAL_RESP;
      bus_pkg::UART_WAIT:
        if (!uart_busy_i)
          state_d = bus_pkg::LOCAL_RESP;
      default:
        state_d = bus_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q   <= bus_pkg::IDLE;
      is_lsu_q  <= 1'b0;
      is_wr_q   <= 1'b0;
      aw_pend_q <= 1'b0;
      w_pend_q  <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (accept)
      begin
        is_lsu_q  <= grant_lsu;
        is_wr_q   <= lsu_wr_req_i;
        aw_pend_q <= 1'b1;
        w_pend_q  <= 1'b1;
      end
      else if (state_q == bus_pkg::AW_W)
      begin
        // each channel drops after its own transfer
        if (m_awready_i)
          aw_pend_q <= 1'b0;
        if (m_wready_i)
          w_pend_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      addr_q  <= sel_addr;
      wdata_q <= lsu_wdata_i;
      wstrb_q <= lsu_wstrb_i;
      rdata_q <= local_rdata;
    end
    else if ((state_q == bus_pkg::R) && m_rvalid_i)
      rdata_q <= m_rdata_i;
  end

  assign m_araddr_o  = addr_q;
  assign m_arvalid_o = (state_q == bus_pkg::AR);
  assign m_rready_o  = (state_q == bus_pkg::R);
  assign m_awaddr_o  = addr_q;
  assign m_awvalid_o = (state_q == bus_pkg::AW_W) && aw_pend_q;
  assign m_wdata_o   = wdata_q;
  assign m_wstrb_o   = wstrb_q;
  assign m_wvalid_o  = (state_q == bus_pkg::AW_W) && w_pend_q;
  assign m_bready_o  = (state_q == bus_pkg::B);

  // one pulse to the owner
  assign ifu_rvalid_o = (state_q == bus_pkg::LOCAL_RESP) && !is_lsu_q;
  assign lsu_rvalid_o = (state_q == bus_pkg::LOCAL_RESP) && is_lsu_q && !is_wr_q;
  assign lsu_wready_o = (state_q == bus_pkg::LOCAL_RESP) && is_wr_q;
  assign ifu_rdata_o  = rdata_q;
  assign lsu_rdata_o  = rdata_q;

endmodule

// ==== hw/bus_clint.sv ====
module bus_clint (
  input  logic                clk,
  input  logic                rst,
  input  logic                wr_en_i,
  input  bus_pkg::clint_reg_t reg_i,
  input  bus_pkg::data_t      wdata_i,
  output bus_pkg::data_t      rdata_o,
  output logic                timer_irq_o
);

  logic [63:0] mtime_q;
  logic [63:0] mtimecmp_q;
  logic        irq_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime_q    <= '0;
      // all ones keeps the interrupt quiet after reset
      mtimecmp_q <= '1;
      irq_q      <= 1'b0;
    end
    else
    begin
      mtime_q <= mtime_q + 64'd1;
      irq_q   <= (mtime_q >= mtimecmp_q);
      // mtime words are read only
      if (wr_en_i && (reg_i == 2'd0))
        mtimecmp_q[31:0] <= wdata_i;
      if (wr_en_i && (reg_i == 2'd1))
        mtimecmp_q[63:32] <= wdata_i;
    end
  end

  always_comb
  begin
    case (reg_i)
      2'd0:    rdata_o = mtimecmp_q[31:0];
      2'd1:    rdata_o = mtimecmp_q[63:32];
      2'd2:    rdata_o = mtime_q[31:0];
      default: rdata_o = mtime_q[63:32];
    endcase
  end

  assign timer_irq_o = irq_q;

endmodule

// ==== hw/bus_pkg.sv ====
package bus_pkg;

  // widths with a meaning on the core and external side
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [7:0]  byte_t;

  // word index inside the timer block
  typedef logic [1:0]  clint_reg_t;

  // timer region, four 32-bit words
  // offset 0/4 mtimecmp low/high, offset 8/12 mtime low/high
  localparam addr_t CLINT_BASE = 32'h0200_0000;
  localparam addr_t CLINT_SIZE = 32'd16;

  // serial transmit data register
  localparam addr_t UART_TX_ADDR = 32'h1000_0000;

  // arbiter states
  // LOCAL_RESP is the single pulse cycle that ends every transaction
  typedef enum logic [2:0] {
    IDLE,
    AR,
    R,
    AW_W,
    B,
    LOCAL_RESP,
    UART_WAIT
  } arb_state_e;

endpackage

// ==== hw/bus_top.sv ====
module bus_top #(
  parameter int BAUD_DIV = 4
) (
  input  logic           clk,
  input  logic           rst,

  input  bus_pkg::addr_t ifu_addr_i,
  input  logic           ifu_req_i,
  output bus_pkg::data_t ifu_rdata_o,
  output logic           ifu_rvalid_o,

  input  bus_pkg::addr_t lsu_addr_i,
  input  logic           lsu_rd_req_i,
  input  logic           lsu_wr_req_i,
  input  bus_pkg::data_t lsu_wdata_i,
  input  bus_pkg::strb_t lsu_wstrb_i,
  output bus_pkg::data_t lsu_rdata_o,
  output logic           lsu_rvalid_o,
  output logic           lsu_wready_o,

  output bus_pkg::addr_t m_araddr_o,
  output logic           m_arvalid_o,
  input  logic           m_arready_i,
  input  bus_pkg::data_t m_rdata_i,
  input  logic           m_rvalid_i,
  output logic           m_rready_o,
  output bus_pkg::addr_t m_awaddr_o,
  output logic           m_awvalid_o,
  input  logic           m_awready_i,
  output bus_pkg::data_t m_wdata_o,
  output bus_pkg::strb_t m_wstrb_o,
  output logic           m_wvalid_o,
  input  logic           m_wready_i,
  input  logic           m_bvalid_i,
  output logic           m_bready_o,

  output logic           uart_tx_o,
  output logic           timer_irq_o
);

  logic                clint_wr_en;
  bus_pkg::clint_reg_t clint_reg;
  bus_pkg::data_t      clint_wdata;
  bus_pkg::data_t      clint_rdata;
  logic                uart_wr_en;
  bus_pkg::byte_t      uart_data;
  logic                uart_busy;

  bus_arbiter_ctrl bus_arbiter_ctrl_i (
    .clk           (clk),
    .rst           (rst),
    .ifu_addr_i    (ifu_addr_i),
    .ifu_req_i     (ifu_req_i),
    .ifu_rdata_o   (ifu_rdata_o),
    .ifu_rvalid_o  (ifu_rvalid_o),
    .lsu_addr_i    (lsu_addr_i),
    .lsu_rd_req_i  (lsu_rd_req_i),
    .lsu_wr_req_i  (lsu_wr_req_i),
    .lsu_wdata_i   (lsu_wdata_i),
    .lsu_wstrb_i   (lsu_wstrb_i),
    .lsu_rdata_o   (lsu_rdata_o),
    .lsu_rvalid_o  (lsu_rvalid_o),
    .lsu_wready_o  (lsu_wready_o),
    .m_araddr_o    (m_araddr_o),
    .m_arvalid_o   (m_arvalid_o),
    .m_arready_i   (m_arready_i),
    .m_rdata_i     (m_rdata_i),
    .m_rvalid_i    (m_rvalid_i),
    .m_rready_o    (m_rready_o),
    .m_awaddr_o    (m_awaddr_o),
    .m_awvalid_o   (m_awvalid_o),
    .m_awready_i   (m_awready_i),
    .m_wdata_o     (m_wdata_o),
    .m_wstrb_o     (m_wstrb_o),
    .m_wvalid_o    (m_wvalid_o),
    .m_wready_i    (m_wready_i),
    .m_bvalid_i    (m_bvalid_i),
    .m_bready_o    (m_bready_o),
    .clint_wr_en_o (clint_wr_en),
    .clint_reg_o   (clint_reg),
    .clint_wdata_o (clint_wdata),
    .clint_rdata_i (clint_rdata),
    .uart_wr_en_o  (uart_wr_en),
    .uart_data_o   (uart_data),
    .uart_busy_i   (uart_busy)
  );

  bus_clint bus_clint_i (
    .clk         (clk),
    .rst         (rst),
    .wr_en_i     (clint_wr_en),
    .reg_i       (clint_reg),
    .wdata_i     (clint_wdata),
    .rdata_o     (clint_rdata),
    .timer_irq_o (timer_irq_o)
  );

  bus_uart_tx #(
    .BAUD_DIV (BAUD_DIV)
  ) bus_uart_tx_i (
    .clk     (clk),
    .rst     (rst),
    .wr_en_i (uart_wr_en),
    .data_i  (uart_data),
    .busy_o  (uart_busy),
    .tx_o    (uart_tx_o)
  );

endmodule

// ==== hw/bus_uart_tx.sv ====
module bus_uart_tx #(
  parameter int BAUD_DIV = 4
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           wr_en_i,
  input  bus_pkg::byte_t data_i,
  output logic           busy_o,
  output logic           tx_o
);

  localparam int CNT_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;

  // cycles inside the current bit
  logic [CNT_W-1:0] baud_cnt_q;
  // index of the bit on the line, 0 is the start bit
  logic [3:0]       bit_cnt_q;
  // stop, data lsb first, start
  logic [9:0]       shift_q;
  logic             busy_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy_q     <= 1'b0;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
      shift_q    <= '1;
    end
    else if (!busy_q)
    begin
      if (wr_en_i)
      begin
        busy_q     <= 1'b1;
        baud_cnt_q <= '0;
        bit_cnt_q  <= '0;
        shift_q    <= {1'b1, data_i, 1'b0};
      end
    end
    else if (baud_cnt_q == CNT_W'(BAUD_DIV - 1))
    begin
      baud_cnt_q <= '0;
      // line idles high once the frame is out
      shift_q    <= {1'b1, shift_q[9:1]};
      if (bit_cnt_q == 4'd9)
        busy_q <= 1'b0;
      else
        bit_cnt_q <= bit_cnt_q + 4'd1;
    end
    else
    begin
      baud_cnt_q <= baud_cnt_q + 1'b1;
    end
  end

  assign busy_o = busy_q;
  assign tx_o   = shift_q[0];

endmodule
